//--- src/cart_pkg.sv
package cart_pkg;

	//////////////////////////////////////////////////
	// Region and loader option encodings
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_e;

	typedef enum logic [1:0] {
		US_EU_JP = 2'd0,  // Default order
		EU_US_JP = 2'd1,
		US_JP_EU = 2'd2,
		JP_US_EU = 2'd3
	} prio_e;

	typedef enum logic [1:0] {
		FILE_EXT = 2'd0,  // Region from download index bits 7:6
		HEADER   = 2'd1,  // Region from cartridge header letters
		DISABLED = 2'd2
	} auto_mode_e;

	typedef enum logic [1:0] {
		Q_SRAM   = 2'd0,
		Q_EEPROM = 2'd1,
		Q_SVP    = 2'd2,
		Q_FMBUSY = 2'd3
	} quirk_e;

	localparam int NUM_QUIRKS = 4;  // Width of the quirk vector

	//////////////////////////////////////////////////
	// Header byte addresses
	//////////////////////////////////////////////////

	localparam int CART_ADDR_W = 25;
	localparam logic [CART_ADDR_W-1:0] HDR_REGION_A = 25'h1F0;  // Region letters
	localparam logic [CART_ADDR_W-1:0] HDR_REGION_B = 25'h1F2;
	localparam logic [CART_ADDR_W-1:0] HDR_END      = 25'h200;  // Header fully written
	localparam logic [CART_ADDR_W-1:0] ID_ADDR_0    = 25'h182;  // Serial, high byte only
	localparam logic [CART_ADDR_W-1:0] ID_ADDR_1    = 25'h184;
	localparam logic [CART_ADDR_W-1:0] ID_ADDR_2    = 25'h186;
	localparam logic [CART_ADDR_W-1:0] ID_ADDR_3    = 25'h188;
	localparam logic [CART_ADDR_W-1:0] ID_ADDR_4    = 25'h18A;  // Serial, low byte only
	localparam logic [CART_ADDR_W-1:0] ID_CHECK     = 25'h18C;  // Compare point

	// Known serials and the quirk each one needs
	localparam int NUM_IDS = 6;
	localparam logic [63:0] ID_TABLE [NUM_IDS] = '{
		"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", "MK-1229 ", "T-35036 "
	};
	localparam quirk_e ID_QUIRK [NUM_IDS] = '{
		Q_SRAM, Q_SRAM, Q_EEPROM, Q_EEPROM, Q_SVP, Q_FMBUSY
	};

endpackage

//--- src/download_capture.sv
`timescale 1ns/10ps

module download_capture #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              rst_n_i,
	input  logic              dl_active_i,  // Download in progress
	input  logic              dl_wr_i,      // One-cycle write strobe
	input  logic [ADDR_W-1:0] dl_addr_i,
	input  logic              wr_done_i,    // Handshake finished
	output logic              wr_start_o,
	output logic              dl_start_o,
	output logic              dl_end_o,
	output logic              dl_wait_o,
	output logic [ADDR_W-1:0] rom_sz_o
);

	logic active_q;  // dl_active_i one cycle late

	//////////////////////////////////////////////////
	// Download edges and write launch
	//////////////////////////////////////////////////

	assign dl_start_o = dl_active_i & ~active_q;  // First active cycle
	assign dl_end_o   = ~dl_active_i & active_q;  // First idle cycle

	// Launch straight from the strobe so req and wait rise together
	assign wr_start_o = dl_wr_i & dl_active_i;

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			active_q <= 1'b0;
		end else begin
			active_q <= dl_active_i;
		end
	end

	//////////////////////////////////////////////////
	// Host wait and final size
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dl_wait_o <= 1'b0;
			rom_sz_o  <= '0;
		end else if (dl_end_o) begin
			rom_sz_o  <= dl_addr_i;  // Last address left on the bus
			dl_wait_o <= 1'b0;       // Never leave the host stalled
		end else if (wr_start_o) begin
			dl_wait_o <= 1'b1;       // Hold host until memory done
		end else if (wr_done_i) begin
			dl_wait_o <= 1'b0;
		end
	end

endmodule

//--- src/header_scan.sv
`timescale 1ns/10ps

module header_scan #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input  logic                            clk_sys,
	input  logic                            rst_n_i,
	input  logic                            dl_start_i,
	input  logic                            dl_end_i,
	input  logic                            dl_active_i,
	input  logic                            dl_wr_i,
	input  logic [ADDR_W-1:0]               dl_addr_i,
	input  logic [DATA_W-1:0]               dl_data_i,
	output logic                            hdr_j_o,      // Japan letter seen
	output logic                            hdr_u_o,      // USA letter seen
	output logic                            hdr_e_o,      // Any other region letter
	output logic                            hdr_ready_o,
	output logic [cart_pkg::NUM_QUIRKS-1:0] quirks_o
);
	import cart_pkg::*;

	logic                  wr_en;      // Valid host write
	logic                  at_reg_a;
	logic                  at_reg_b;
	logic [2:0]            lo_flags;   // {j,u,e} from low byte
	logic [2:0]            hi_flags;   // {j,u,e} from high byte
	logic [63:0]           cart_id;    // ASCII serial, first char on top
	logic [NUM_QUIRKS-1:0] quirk_hit;

	// Maps one header character onto {j,u,e}
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		logic [2:0] f;
		f = 3'b000;
		if (c == "J")
			f[2] = 1'b1;
		else if (c == "U")
			f[1] = 1'b1;
		else if (c >= "0" && c <= "Z")
			f[0] = 1'b1;  // Digits and other letters count as EU
		return f;
	endfunction

	//////////////////////////////////////////////////
	// Region letters
	//////////////////////////////////////////////////

	assign wr_en    = dl_wr_i & dl_active_i;
	assign at_reg_a = wr_en && (dl_addr_i == ADDR_W'(HDR_REGION_A));
	assign at_reg_b = wr_en && (dl_addr_i == ADDR_W'(HDR_REGION_B));
	assign lo_flags = (at_reg_a || at_reg_b) ? letter_flags(dl_data_i[7:0]) : 3'b000;
	assign hi_flags = at_reg_a ? letter_flags(dl_data_i[15:8]) : 3'b000;  // Only word A

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hdr_j_o <= 1'b0;
			hdr_u_o <= 1'b0;
			hdr_e_o <= 1'b0;
		end else if (dl_start_i) begin  // Fresh image
			hdr_j_o <= 1'b0;
			hdr_u_o <= 1'b0;
			hdr_e_o <= 1'b0;
		end else begin
			hdr_j_o <= hdr_j_o | lo_flags[2] | hi_flags[2];  // Sticky
			hdr_u_o <= hdr_u_o | lo_flags[1] | hi_flags[1];
			hdr_e_o <= hdr_e_o | lo_flags[0] | hi_flags[0];
		end
	end

	// Header complete marker, held until download end
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i)
			hdr_ready_o <= 1'b0;
		else if (dl_end_i)
			hdr_ready_o <= 1'b0;
		else if (wr_en && dl_addr_i == ADDR_W'(HDR_END))
			hdr_ready_o <= 1'b1;
	end

	//////////////////////////////////////////////////
	// Serial ID and quirks
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			case (dl_addr_i)
				ADDR_W'(ID_ADDR_0): cart_id[63:56] <= dl_data_i[15:8];
				ADDR_W'(ID_ADDR_1): cart_id[55:40] <= {dl_data_i[7:0], dl_data_i[15:8]};
				ADDR_W'(ID_ADDR_2): cart_id[39:24] <= {dl_data_i[7:0], dl_data_i[15:8]};
				ADDR_W'(ID_ADDR_3): cart_id[23:8]  <= {dl_data_i[7:0], dl_data_i[15:8]};
				ADDR_W'(ID_ADDR_4): cart_id[7:0]   <= dl_data_i[7:0];
				default: ;  // Other words leave the serial alone
			endcase
		end
	end

	// Table lookup, each entry lights its own quirk bit
	always_comb begin
		quirk_hit = '0;
		for (int i = 0; i < NUM_IDS; i++) begin
			if (cart_id == ID_TABLE[i])
				quirk_hit[ID_QUIRK[i]] = 1'b1;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i)
			quirks_o <= '0;
		else if (dl_start_i)
			quirks_o <= '0;
		else if (wr_en && dl_addr_i == ADDR_W'(ID_CHECK))
			quirks_o <= quirks_o | quirk_hit;  // Serial is complete here
	end

endmodule

//--- src/region_select.sv
`timescale 1ns/10ps

module region_select (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	input  logic                 hdr_ready_i,
	input  logic                 hdr_j_i,
	input  logic                 hdr_u_i,
	input  logic                 hdr_e_i,
	input  logic [7:0]           dl_index_i,   // File-extension index
	input  cart_pkg::auto_mode_e cfg_auto_i,
	input  cart_pkg::prio_e      cfg_prio_i,
	output cart_pkg::region_e    region_o,
	output logic                 region_set_o  // Region request valid
);
	import cart_pkg::*;

	logic ready_q;
	logic ready_rise;
	logic ready_fall;

	// First flagged region in the given order, else the order's head
	function automatic region_e pick_region(input prio_e p, input logic j, u, e);
		region_e r;
		case (p)
			US_EU_JP: r = u ? US : (e ? EU : (j ? JP : US));
			EU_US_JP: r = e ? EU : (u ? US : (j ? JP : EU));
			US_JP_EU: r = u ? US : (j ? JP : (e ? EU : US));
			JP_US_EU: r = j ? JP : (u ? US : (e ? EU : JP));
		endcase
		return r;
	endfunction

	assign ready_rise = hdr_ready_i & ~ready_q;
	assign ready_fall = ~hdr_ready_i & ready_q;  // Download has ended

	//////////////////////////////////////////////////
	// Region decision
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ready_q      <= 1'b0;
			region_o     <= JP;
			region_set_o <= 1'b0;
		end else begin
			ready_q <= hdr_ready_i;
			if (ready_rise && cfg_auto_i == HEADER) begin
				region_o     <= pick_region(cfg_prio_i, hdr_j_i, hdr_u_i, hdr_e_i);
				region_set_o <= 1'b1;
			end else if (ready_rise && cfg_auto_i == FILE_EXT) begin
				region_o     <= region_e'(dl_index_i[7:6]);
				region_set_o <= |dl_index_i;  // Index 0 means no hint
			end else if (ready_fall) begin
				region_set_o <= 1'b0;
			end
		end
	end

endmodule

//--- src/rom_write_port.sv
`timescale 1ns/10ps

module rom_write_port #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input  logic              clk_sys,
	input  logic              rst_n_i,
	input  logic              wr_start_i,  // Capture this cycle's word
	input  logic [ADDR_W-1:0] dl_addr_i,   // Byte address
	input  logic [DATA_W-1:0] dl_data_i,
	input  logic              mem_ack_i,
	output logic              mem_req_o,
	output logic [ADDR_W-2:0] mem_addr_o,  // Word address
	output logic [DATA_W-1:0] mem_data_o,
	output logic              wr_done_o
);

	localparam int HALF_W = DATA_W / 2;  // Byte width

	logic ack_seen;  // Ack taken, waiting for it to drop
	logic busy;
	logic take;

	assign busy = mem_req_o | ack_seen;
	assign take = wr_start_i & ~busy;

	// Fourth phase, ack back low after req dropped
	assign wr_done_o = ack_seen & ~mem_ack_i;

	//////////////////////////////////////////////////
	// Word capture
	always_ff @(posedge clk_sys) begin
		if (take) begin
			mem_addr_o <= dl_addr_i[ADDR_W-1:1];  // Byte to word address
			mem_data_o <= {dl_data_i[HALF_W-1:0], dl_data_i[DATA_W-1:HALF_W]};  // Byte swap
		end
	end

	//////////////////////////////////////////////////
	// Four-phase handshake
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_req_o <= 1'b0;
			ack_seen  <= 1'b0;
		end else if (take) begin
			mem_req_o <= 1'b1;                // Phase 1, req up
		end else if (mem_req_o && mem_ack_i) begin
			mem_req_o <= 1'b0;                // Phase 2 seen, drop req
			ack_seen  <= 1'b1;
		end else if (wr_done_o) begin
			ack_seen  <= 1'b0;                // Back to idle
		end
	end

endmodule

//--- src/cart_loader_top.sv
`timescale 1ns/10ps

module cart_loader_top #(
	parameter int ADDR_W = 25,  // Host byte address width
	parameter int DATA_W = 16   // Host word width
) (
	input  logic                            clk_sys,
	input  logic                            rst_n_i,
	// Host download bus
	input  logic                            dl_active_i,
	input  logic                            dl_wr_i,
	input  logic [ADDR_W-1:0]               dl_addr_i,
	input  logic [DATA_W-1:0]               dl_data_i,
	input  logic [7:0]                      dl_index_i,
	output logic                            dl_wait_o,
	// Configuration
	input  cart_pkg::auto_mode_e            cfg_auto_i,
	input  cart_pkg::prio_e                 cfg_prio_i,
	// ROM memory, four-phase req/ack
	output logic                            mem_req_o,
	output logic [ADDR_W-2:0]               mem_addr_o,  // Word address
	output logic [DATA_W-1:0]               mem_data_o,
	input  logic                            mem_ack_i,
	// Results
	output logic [ADDR_W-1:0]               rom_sz_o,
	output cart_pkg::region_e               region_o,
	output logic                            region_set_o,
	output logic [cart_pkg::NUM_QUIRKS-1:0] quirks_o
);

	logic wr_start;   // Capture -> write port
	logic wr_done;    // Write port -> capture
	logic dl_start;
	logic dl_end;
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	//////////////////////////////////////////////////
	// Input side
	download_capture #(.ADDR_W(ADDR_W)) u_capture (
		.clk_sys    (clk_sys),
		.rst_n_i    (rst_n_i),
		.dl_active_i(dl_active_i),
		.dl_wr_i    (dl_wr_i),
		.dl_addr_i  (dl_addr_i),
		.wr_done_i  (wr_done),
		.wr_start_o (wr_start),
		.dl_start_o (dl_start),
		.dl_end_o   (dl_end),
		.dl_wait_o  (dl_wait_o),
		.rom_sz_o   (rom_sz_o)
	);

	//////////////////////////////////////////////////
	// Processing
	header_scan #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_scan (
		.clk_sys    (clk_sys),
		.rst_n_i    (rst_n_i),
		.dl_start_i (dl_start),
		.dl_end_i   (dl_end),
		.dl_active_i(dl_active_i),
		.dl_wr_i    (dl_wr_i),
		.dl_addr_i  (dl_addr_i),
		.dl_data_i  (dl_data_i),
		.hdr_j_o    (hdr_j),
		.hdr_u_o    (hdr_u),
		.hdr_e_o    (hdr_e),
		.hdr_ready_o(hdr_ready),
		.quirks_o   (quirks_o)
	);

	region_select u_region (
		.clk_sys     (clk_sys),
		.rst_n_i     (rst_n_i),
		.hdr_ready_i (hdr_ready),
		.hdr_j_i     (hdr_j),
		.hdr_u_i     (hdr_u),
		.hdr_e_i     (hdr_e),
		.dl_index_i  (dl_index_i),
		.cfg_auto_i  (cfg_auto_i),
		.cfg_prio_i  (cfg_prio_i),
		.region_o    (region_o),
		.region_set_o(region_set_o)
	);

	//////////////////////////////////////////////////
	// Output side
	rom_write_port #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_wport (
		.clk_sys   (clk_sys),
		.rst_n_i   (rst_n_i),
		.wr_start_i(wr_start),
		.dl_addr_i (dl_addr_i),
		.dl_data_i (dl_data_i),
		.mem_ack_i (mem_ack_i),
		.mem_req_o (mem_req_o),
		.mem_addr_o(mem_addr_o),
		.mem_data_o(mem_data_o),
		.wr_done_o (wr_done)
	);

endmodule

//--- verification/cart_loader_checker.sv
`timescale 1ns/10ps

module cart_loader_checker #(
	parameter int ADDR_W = 25,
	parameter int DATA_W = 16
) (
	input logic              clk_sys,
	input logic              rst_n_i,
	input logic              mem_req_i,   // From the write port
	input logic              mem_ack_i,
	input logic [ADDR_W-2:0] mem_addr_i,
	input logic [DATA_W-1:0] mem_data_i,
	input logic              dl_wait_i    // From the capture block
);

	//////////////////////////////////////////////////
	// ROM handshake rules

	// Request may only drop once the ack is in
	req_holds: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(mem_req_i && !mem_ack_i) |=> mem_req_i)
		else $error("mem_req_o dropped before mem_ack_i arrived");

	word_stable: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(mem_req_i && $past(mem_req_i)) |-> ($stable(mem_addr_i) && $stable(mem_data_i)))
		else $error("ROM address or data changed while mem_req_o was high");

	//////////////////////////////////////////////////
	// Host wait covers every request
	wait_covers_req: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		mem_req_i |-> dl_wait_i)
		else $error("mem_req_o high while dl_wait_o low");

endmodule

//--- verification/cart_loader_tb.sv
`timescale 1ns/10ps

module cart_loader_tb;
	import cart_pkg::*;

	localparam int ADDR_W = 25;
	localparam int DATA_W = 16;
	localparam logic [31:0] SEED = 32'h866eb043;

	// Run limit from the host words and downloads of all tests
	localparam int NUM_WRITES     = 8 + 32 * 3 + 6 + 7 * 6;
	localparam int NUM_DLS        = 1 + 32 + 6 + 7;
	localparam int TIMEOUT_CYCLES = 2 * (16 + NUM_WRITES * 10 + NUM_DLS * 8);

	// Expected serials and quirk vectors with an unknown serial last
	localparam logic [63:0] EXP_IDS [7] = '{
		"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", "MK-1229 ", "T-35036 ", "XX-00000"
	};
	localparam logic [3:0] EXP_QUIRKS [7] = '{
		4'b0001, 4'b0001, 4'b0010, 4'b0010, 4'b0100, 4'b1000, 4'b0000
	};
	localparam logic [7:0] EXT_INDEX [5] = '{8'h00, 8'h40, 8'h3F, 8'h81, 8'hC0};

	logic                  clk_sys;
	logic                  rst_n_i;
	logic                  dl_active_i;
	logic                  dl_wr_i;
	logic [ADDR_W-1:0]     dl_addr_i;
	logic [DATA_W-1:0]     dl_data_i;
	logic [7:0]            dl_index_i;
	logic                  dl_wait_o;
	auto_mode_e            cfg_auto_i;
	prio_e                 cfg_prio_i;
	logic                  mem_req_o;
	logic [ADDR_W-2:0]     mem_addr_o;
	logic [DATA_W-1:0]     mem_data_o;
	logic                  mem_ack_i = 1'b0;
	logic [ADDR_W-1:0]     rom_sz_o;
	region_e               region_o;
	logic                  region_set_o;
	logic [NUM_QUIRKS-1:0] quirks_o;

	logic [DATA_W-1:0] rom_mem [1024];  // Model of the external ROM
	logic [31:0]       stim_lfsr;       // Data and address draws
	logic [31:0]       delay_lfsr;      // Ack delay draws
	logic              ack_pending;
	int                ack_delay;
	int                write_count;
	int                mismatch_count;
	int                fail_count;
	int                cycle_count = 0;

	cart_loader_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) UUT (.*);

	bind cart_loader_top cart_loader_checker #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) hs_checker (
		.clk_sys   (clk_sys),
		.rst_n_i   (rst_n_i),
		.mem_req_i (mem_req_o),
		.mem_ack_i (mem_ack_i),
		.mem_addr_i(mem_addr_o),
		.mem_data_i(mem_data_o),
		.dl_wait_i (dl_wait_o)
	);

	always #50 clk_sys = ~clk_sys;  // 100 ns period

	// Galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, inout logic [31:0] state, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v     = {v[30:0], state[0]};  // One step per bit
			state = lfsr_step(state);
		end
	endtask

	task automatic report_mismatch(input string test, input logic [63:0] exp, act);
		mismatch_count++;
		$display("ERROR %s: expected %0h, actual %0h", test, exp, act);
	endtask

	// First flagged region in order p or else the order's head
	// Flags in f are {j,u,e}
	function automatic int expected_region(input int p, input logic [2:0] f);
		int order [3];
		int r;
		case (p)
			0:       order = '{1, 2, 0};  // US EU JP
			1:       order = '{2, 1, 0};  // EU US JP
			2:       order = '{1, 0, 2};  // US JP EU
			default: order = '{0, 1, 2};  // JP US EU
		endcase
		r = order[0];
		for (int k = 2; k >= 0; k--) begin
			if (f[2 - order[k]])
				r = order[k];
		end
		return r;
	endfunction

	//////////////////////////////////////////////////
	// ROM responder with a random ack delay of 0 to 3 cycles
	always @(negedge clk_sys) begin : responder
		logic [31:0] bits;
		if (!rst_n_i) begin
			mem_ack_i   = 1'b0;
			ack_pending = 1'b0;
			ack_delay   = 0;
			write_count = 0;
			delay_lfsr  = SEED;
			for (int i = 0; i < 1024; i++)
				rom_mem[i] = 16'(i * 37) ^ 16'hC3A5;  // Address-dependent fill
		end else if (mem_req_o && !mem_ack_i) begin
			if (!ack_pending) begin  // New request
				draw_bits(2, delay_lfsr, bits);
				ack_delay   = int'(bits[1:0]);
				ack_pending = 1'b1;
			end
			if (ack_delay == 0) begin
				mem_ack_i   = 1'b1;
				ack_pending = 1'b0;
				rom_mem[mem_addr_o[9:0]] = mem_data_o;
				write_count++;
			end else begin
				ack_delay--;
			end
		end else if (!mem_req_o && mem_ack_i) begin
			mem_ack_i = 1'b0;  // Fourth phase
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Host bus tasks that start on a falling edge
	task automatic start_download(input logic [7:0] idx);
		dl_index_i  = idx;
		dl_active_i = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		dl_active_i = 1'b0;
		repeat (2) @(negedge clk_sys);  // Edge pulse and then the region clear
	endtask

	task automatic write_word(input string test, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		int count_before;
		count_before = write_count;
		@(negedge clk_sys);
		dl_wr_i   = 1'b1;
		dl_addr_i = addr;
		dl_data_i = data;
		@(negedge clk_sys);
		dl_wr_i = 1'b0;
		if (!dl_wait_o) begin
			fail_count++;
			$display("%s: dl_wait_o did not rise after the write to %0h", test, addr);
		end
		while (dl_wait_o)
			@(negedge clk_sys);
		if (write_count != count_before + 1)  // Word lost or doubled
			report_mismatch({test, "_count"}, 64'(count_before + 1), 64'(write_count));
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	task automatic rom_write_readback();
		logic [31:0]       bits;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		cfg_auto_i = DISABLED;
		addr = '0;
		start_download(8'h00);
		for (int i = 0; i < 8; i++) begin
			draw_bits(9, stim_lfsr, bits);
			addr = ADDR_W'(32'h400) + ADDR_W'({bits[8:0], 1'b0});  // Clear of the header
			draw_bits(16, stim_lfsr, bits);
			data = bits[15:0];
			write_word("rom_writes", addr, data);
			if (mem_addr_o !== (ADDR_W-1)'(addr >> 1))  // Full word address
				report_mismatch("rom_addr", 64'(addr >> 1), 64'(mem_addr_o));
			if (rom_mem[addr[10:1]] !== {data[7:0], data[15:8]})  // Bytes swapped
				report_mismatch("rom_writes", 64'({data[7:0], data[15:8]}),
					64'(rom_mem[addr[10:1]]));
		end
		end_download();
		if (rom_sz_o !== addr)
			report_mismatch("rom_size", 64'(addr), 64'(rom_sz_o));
	endtask

	task automatic header_region_sweep();
		logic [2:0] flags;
		logic [7:0] cj;
		logic [7:0] cu;
		logic [7:0] ce;
		int         exp_region;
		cfg_auto_i = HEADER;
		for (int p = 0; p < 4; p++) begin
			for (int f = 0; f < 8; f++) begin
				flags      = 3'(f);
				cfg_prio_i = prio_e'(p[1:0]);
				cj = flags[2] ? "J" : " ";  // Space flags nothing
				cu = flags[1] ? "U" : " ";
				ce = flags[0] ? "E" : " ";
				start_download(8'h00);
				write_word("header_region", HDR_REGION_A, {cj, cu});
				write_word("header_region", HDR_REGION_B, {8'h20, ce});
				write_word("header_region", HDR_END, 16'h0000);
				exp_region = expected_region(p, flags);
				if (region_o !== 2'(exp_region))
					report_mismatch("header_region", 64'(exp_region), 64'(region_o));
				if (region_set_o !== 1'b1)
					report_mismatch("header_region_set", 64'(1), 64'(region_set_o));
				end_download();
				if (region_set_o !== 1'b0)  // Dropped after download end
					report_mismatch("header_region_clear", 64'(0), 64'(region_set_o));
			end
		end
	endtask

	task automatic file_ext_region();
		logic [1:0] prev_region;
		cfg_auto_i = FILE_EXT;
		for (int k = 0; k < 5; k++) begin
			start_download(EXT_INDEX[k]);
			write_word("file_ext", HDR_END, 16'h0000);
			if (region_o !== EXT_INDEX[k][7:6])
				report_mismatch("file_ext", 64'(EXT_INDEX[k][7:6]), 64'(region_o));
			if (region_set_o !== (EXT_INDEX[k] != 8'h00))
				report_mismatch("file_ext_set", 64'(EXT_INDEX[k] != 8'h00), 64'(region_set_o));
			end_download();
		end
		// Region and flag keep their values in disabled mode
		prev_region = region_o;
		cfg_auto_i  = DISABLED;
		start_download(8'h40);
		write_word("disabled", HDR_END, 16'h0000);
		if (region_o !== prev_region)
			report_mismatch("disabled", 64'(prev_region), 64'(region_o));
		if (region_set_o !== 1'b0)
			report_mismatch("disabled_set", 64'(0), 64'(region_set_o));
		end_download();
	endtask

	task automatic quirk_id_table();
		logic [63:0] id;
		cfg_auto_i = DISABLED;
		for (int k = 0; k < 7; k++) begin
			id = EXP_IDS[k];
			start_download(8'h00);
			if (quirks_o !== 4'b0000)  // Flags of the last image gone
				report_mismatch("quirks_clear", 64'(0), 64'(quirks_o));
			write_word("quirks", ID_ADDR_0, {id[63:56], 8'h00});
			write_word("quirks", ID_ADDR_1, {id[47:40], id[55:48]});
			write_word("quirks", ID_ADDR_2, {id[31:24], id[39:32]});
			write_word("quirks", ID_ADDR_3, {id[15:8], id[23:16]});
			write_word("quirks", ID_ADDR_4, {8'h00, id[7:0]});
			write_word("quirks", ID_CHECK, 16'h0000);
			if (quirks_o !== EXP_QUIRKS[k])
				report_mismatch("quirks", 64'(EXP_QUIRKS[k]), 64'(quirks_o));
			end_download();
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	initial begin
		clk_sys        = 1'b0;
		rst_n_i        = 1'b0;
		dl_active_i    = 1'b0;
		dl_wr_i        = 1'b0;
		dl_addr_i      = '0;
		dl_data_i      = '0;
		dl_index_i     = 8'h00;
		cfg_auto_i     = DISABLED;
		cfg_prio_i     = US_EU_JP;
		stim_lfsr      = SEED;
		mismatch_count = 0;
		fail_count     = 0;
		repeat (16) @(negedge clk_sys);
		rst_n_i = 1'b1;
		rom_write_readback();
		header_region_sweep();
		file_ext_region();
		quirk_id_table();
		repeat (4) @(negedge clk_sys);
		$display("Value mismatches: %0d, other failures: %0d", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- cart_loader.f
src/cart_pkg.sv
src/download_capture.sv
src/header_scan.sv
src/region_select.sv
src/rom_write_port.sv
src/cart_loader_top.sv
verification/cart_loader_checker.sv
verification/cart_loader_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := cart_loader_tb
FILELIST  := cart_loader.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
